//--- src/busPkg.sv
// APB data bus package with bus widths, request and response structs and the address map
package busPkg;

    // Bus widths
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;
    localparam int StrbWidth = DataWidth / 8;  // One strobe per byte lane

    // Master to slave, 71 bits
    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [AddrWidth-1:0] paddr;
        logic [DataWidth-1:0] pwdata;
        logic [StrbWidth-1:0] pstrb;    // Byte enables for writes
    } apbReq_t;

    // Slave to master, 34 bits
    typedef struct packed {
        logic [DataWidth-1:0] prdata;
        logic                 pready;
        logic                 pslverr;
    } apbRsp_t;

    // Memory map of the data bus
    localparam logic [AddrWidth-1:0] RamBase       = 32'h1001_0000;  // Start of data segment
    localparam logic [AddrWidth-1:0] StopwatchBase = 32'hFF20_0050;
    localparam logic [AddrWidth-1:0] LfsrBase      = 32'hFF20_0060;

    // Each register device answers in a 16 byte window
    localparam logic [AddrWidth-1:0] DevWindow = 32'd16;

endpackage

//--- src/periphPkg.sv
// Peripheral register map package with offsets, stopwatch control bits and LFSR constants
package periphPkg;

    // Stopwatch registers
    localparam logic [31:0] SwCtrlOffset  = 32'h0;  // Control, run and clear
    localparam logic [31:0] SwCountOffset = 32'h4;  // Milliseconds since clear

    // Control register bits
    localparam int SwRunBit   = 0;  // Level, counts while set
    localparam int SwClearBit = 1;  // Pulse on write, not stored

    // LFSR register
    localparam logic [31:0] LfsrDataOffset = 32'h0;  // Read state, write seed

    // Galois feedback taps
    localparam logic [31:0] LfsrPoly = 32'h8020_0003;

    // Reset state, and the fallback when a zero seed is written
    localparam logic [31:0] LfsrDefaultSeed = 32'h0000_0001;

endpackage

//--- src/apbDecoder.sv
// APB address decoder that routes transfers to the devices and merges their responses
`timescale 1ns/10ps

module apbDecoder #(
    parameter int RamWords = 256
) (
    input  busPkg::apbReq_t req,
    output busPkg::apbReq_t ramReq,
    output busPkg::apbReq_t swReq,
    output busPkg::apbReq_t lfsrReq,
    input  busPkg::apbRsp_t ramRsp,
    input  busPkg::apbRsp_t swRsp,
    input  busPkg::apbRsp_t lfsrRsp,
    output busPkg::apbRsp_t rsp
);

    localparam int unsigned RamBytes = RamWords * 4;  // Mapped RAM size in bytes

    logic [busPkg::AddrWidth-1:0] ramOff;
    logic [busPkg::AddrWidth-1:0] swOff;
    logic [busPkg::AddrWidth-1:0] lfsrOff;
    logic ramHit;
    logic swHit;
    logic lfsrHit;
    logic unmapped;

    // Copy of the request with select gated and address rebased to the device
    function automatic busPkg::apbReq_t gateReq(
        input busPkg::apbReq_t r,
        input logic            hit,
        input logic [busPkg::AddrWidth-1:0] off
    );
        busPkg::apbReq_t g;
        g         = r;
        g.psel    = r.psel & hit;
        g.penable = r.penable & hit;
        g.paddr   = off;
        return g;
    endfunction

    // Unsigned subtract wraps below the base, so one compare covers both bounds
    assign ramOff  = req.paddr - busPkg::RamBase;
    assign swOff   = req.paddr - busPkg::StopwatchBase;
    assign lfsrOff = req.paddr - busPkg::LfsrBase;

    assign ramHit  = ramOff < RamBytes;           // Beyond RamWords is an error
    assign swHit   = swOff < busPkg::DevWindow;
    assign lfsrHit = lfsrOff < busPkg::DevWindow;

    assign unmapped = req.psel & ~(ramHit | swHit | lfsrHit);

    assign ramReq  = gateReq(req, ramHit, ramOff);
    assign swReq   = gateReq(req, swHit, swOff);
    assign lfsrReq = gateReq(req, lfsrHit, lfsrOff);

    // Response mux
    always_comb begin
        rsp = '0;  // Idle bus reads back all low
        if (ramReq.psel) begin
            rsp = ramRsp;
        end else if (swReq.psel) begin
            rsp = swRsp;
        end else if (lfsrReq.psel) begin
            rsp = lfsrRsp;
        end else if (unmapped && req.penable) begin
            rsp.pready  = 1'b1;  // Answered here with no wait state
            rsp.pslverr = 1'b1;
        end
    end

    // Sampled values at the access edge belong to the setup phase
    aSetupBeforeAccess: assert property (@(posedge req.penable) req.psel)
        else $error("penable raised without psel");

    aOneSelect: assert property (@(posedge req.penable)
        $onehot0({ramReq.psel, swReq.psel, lfsrReq.psel}))
        else $error("More than one device selected");

endmodule

//--- src/dataRam.sv
// Byte-strobed data RAM on APB with one wait state on reads
`timescale 1ns/10ps

module dataRam #(
    parameter int RamWords = 256
) (
    input  logic            iCLK,
    input  logic            rstN,
    input  busPkg::apbReq_t req,
    output busPkg::apbRsp_t rsp
);

    localparam int IdxWidth = (RamWords > 1) ? $clog2(RamWords) : 1;

    logic [busPkg::DataWidth-1:0] mem [RamWords];
    logic [busPkg::DataWidth-1:0] rdData;   // Word captured in the wait state
    logic                         rdValid;  // High in the second access cycle of a read
    logic [IdxWidth-1:0]          wordIdx;
    logic                         wrEn;
    logic                         rdCapture;

    assign wordIdx = req.paddr[IdxWidth+1:2];  // Word address, byte bits dropped

    assign wrEn      = req.psel & req.penable & req.pwrite;  // Zero wait writes
    assign rdCapture = req.psel & req.penable & ~req.pwrite & ~rdValid;

    // Storage, one lane per strobe bit
    always_ff @(posedge iCLK) begin
        if (wrEn) begin
            for (int lane = 0; lane < busPkg::StrbWidth; lane++) begin
                if (req.pstrb[lane]) begin
                    mem[wordIdx][8*lane +: 8] <= req.pwdata[8*lane +: 8];
                end
            end
        end
        if (rdCapture) begin
            rdData <= mem[wordIdx];
        end
    end

    // Wait state flag
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdCapture;  // Drops again on the completing edge
        end
    end

    always_comb begin
        rsp.prdata  = rdValid ? rdData : '0;
        rsp.pready  = req.psel & req.penable & (req.pwrite | rdValid);
        rsp.pslverr = 1'b0;  // Range errors come from the decoder
    end

    // A write with no lanes would silently do nothing
    aStrbNonZero: assert property (@(posedge iCLK) disable iff (!rstN)
        wrEn |-> req.pstrb != '0)
        else $error("RAM write with empty pstrb");

endmodule

//--- src/stopwatchTimer.sv
// Millisecond stopwatch with prescaler and run/clear control register on APB
`timescale 1ns/10ps

module stopwatchTimer #(
    parameter int ClkPerMs = 25000
) (
    input  logic            iCLK,
    input  logic            rstN,
    input  busPkg::apbReq_t req,
    output busPkg::apbRsp_t rsp
);

    localparam int PreWidth = $clog2(ClkPerMs + 1);

    logic                         run;
    logic [PreWidth-1:0]          preCnt;   // Clocks within the current ms
    logic [busPkg::DataWidth-1:0] msCount;
    logic                         ctrlWr;
    logic                         clrWr;
    logic                         msTick;

    // Zero wait state, so the write lands on the first access edge
    assign ctrlWr = req.psel & req.penable & req.pwrite
                  & (req.paddr == periphPkg::SwCtrlOffset);
    assign clrWr  = ctrlWr & req.pwdata[periphPkg::SwClearBit];

    assign msTick = run & (preCnt == PreWidth'(ClkPerMs - 1));

    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            run <= 1'b0;
        end else if (ctrlWr) begin
            run <= req.pwdata[periphPkg::SwRunBit];
        end
    end

    // Prescaler and ms counter
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            preCnt  <= '0;
            msCount <= '0;
        end else if (clrWr) begin
            preCnt  <= '0;  // Fresh ms starts with the count
            msCount <= '0;
        end else if (msTick) begin
            preCnt  <= '0;
            msCount <= msCount + 1'b1;
        end else if (run) begin
            preCnt <= preCnt + 1'b1;
        end
    end

    // Register read mux
    always_comb begin
        rsp         = '0;
        rsp.pready  = req.psel & req.penable;
        if (req.psel && !req.pwrite) begin
            if (req.paddr == periphPkg::SwCtrlOffset) begin
                rsp.prdata[periphPkg::SwRunBit] = run;  // Clear bit reads as 0
            end else if (req.paddr == periphPkg::SwCountOffset) begin
                rsp.prdata = msCount;
            end
        end
    end

    // Stopped watch holds its value
    aHoldWhenStopped: assert property (@(posedge iCLK) disable iff (!rstN)
        !run && !clrWr |=> $stable(msCount))
        else $error("Stopwatch count moved while stopped");

endmodule

//--- src/lfsrReg.sv
// Galois LFSR register on APB that steps on every read and can be seeded by a write
`timescale 1ns/10ps

module lfsrReg (
    input  logic            iCLK,
    input  logic            rstN,
    input  busPkg::apbReq_t req,
    output busPkg::apbRsp_t rsp
);

    logic [31:0] state;
    logic [31:0] nextState;
    logic        dataSel;
    logic        rdDone;
    logic        wrDone;

    assign dataSel = req.psel & req.penable & (req.paddr == periphPkg::LfsrDataOffset);
    assign rdDone  = dataSel & ~req.pwrite;  // Completes in the first access cycle
    assign wrDone  = dataSel & req.pwrite;

    // Shift right, fold taps in when a one falls out
    assign nextState = {1'b0, state[31:1]} ^ (state[0] ? periphPkg::LfsrPoly : 32'h0);

    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            state <= periphPkg::LfsrDefaultSeed;
        end else if (wrDone) begin
            // Zero is a lockup state
            state <= (req.pwdata != '0) ? req.pwdata : periphPkg::LfsrDefaultSeed;
        end else if (rdDone) begin
            state <= nextState;  // Next read sees the stepped value
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.pready  = req.psel & req.penable;
        rsp.prdata  = rdDone ? state : '0;  // Other offsets read zero
    end

    aNeverZero: assert property (@(posedge iCLK) disable iff (!rstN) state != '0)
        else $error("LFSR state reached zero");

endmodule

//--- src/periphSubsystem.sv
// Data bus subsystem joining the APB decoder to RAM, stopwatch and LFSR
`timescale 1ns/10ps

module periphSubsystem #(
    parameter int RamWords = 256,
    parameter int ClkPerMs = 25000
) (
    input  logic            iCLK,
    input  logic            rstN,
    input  busPkg::apbReq_t req,
    output busPkg::apbRsp_t rsp
);

    busPkg::apbReq_t ramReq;
    busPkg::apbReq_t swReq;
    busPkg::apbReq_t lfsrReq;
    busPkg::apbRsp_t ramRsp;
    busPkg::apbRsp_t swRsp;
    busPkg::apbRsp_t lfsrRsp;

    apbDecoder #(.RamWords(RamWords)) u_apbDecoder (
        .req     (req),
        .ramReq  (ramReq),
        .swReq   (swReq),
        .lfsrReq (lfsrReq),
        .ramRsp  (ramRsp),
        .swRsp   (swRsp),
        .lfsrRsp (lfsrRsp),
        .rsp     (rsp)
    );

    // Data segment
    dataRam #(.RamWords(RamWords)) u_dataRam (
        .iCLK (iCLK),
        .rstN (rstN),
        .req  (ramReq),
        .rsp  (ramRsp)
    );

    stopwatchTimer #(.ClkPerMs(ClkPerMs)) u_stopwatchTimer (
        .iCLK (iCLK),
        .rstN (rstN),
        .req  (swReq),
        .rsp  (swRsp)
    );

    lfsrReg u_lfsrReg (
        .iCLK (iCLK),
        .rstN (rstN),
        .req  (lfsrReq),
        .rsp  (lfsrRsp)
    );

endmodule

//--- tb/tbPeriph.sv
// Testbench for the APB peripheral subsystem, driven from a transfer list with an LFSR model
`timescale 1ns/10ps

module tbPeriph;

    localparam int          TimeoutCycles = 20;   // Per wait for pready
    localparam int          MinRunCycles  = 40;
    localparam logic [31:0] ModelPoly     = 32'h8020_0003;
    localparam logic [31:0] ModelDefault  = 32'h0000_0001;
    localparam logic [31:0] SwCtrl  = busPkg::StopwatchBase + periphPkg::SwCtrlOffset;
    localparam logic [31:0] SwCount = busPkg::StopwatchBase + periphPkg::SwCountOffset;
    localparam string       StimPath = "tb/stimInput.txt";

    logic            clk = 1'b0;
    logic            rstN;
    busPkg::apbReq_t req;
    busPkg::apbRsp_t rsp;
    int              testCount;
    int              passCount;
    int              failCount;
    logic            timedOut;

    always #20 clk = ~clk;  // 40 ns period

    periphSubsystem #(.ClkPerMs(4)) u_periphSubsystem (
        .iCLK (clk),
        .rstN (rstN),
        .req  (req),
        .rsp  (rsp)
    );

    // Reference Galois step for the LFSR reads
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ ModelPoly;  // A one fell out
        end
        return n;
    endfunction

    task automatic checkValue(input string what, input string sigName,
                              input logic [31:0] got, input logic [31:0] exp);
        testCount++;
        assert (got === exp) begin
            passCount++;
            $display("Test %0d ok: %s", testCount, what);
        end else begin
            failCount++;
            $display("Error at %0t: %s = 0x%08h, expected 0x%08h (%s)",
                     $time, sigName, got, exp, what);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what, input string problem);
        testCount++;
        assert (cond) begin
            passCount++;
            $display("Test %0d ok: %s", testCount, what);
        end else begin
            failCount++;
            $display("Test %0d failed at %0t: %s", testCount, $time, problem);
        end
    endtask

    task automatic idleRandom();
        int unsigned n;
        n = $urandom % 4;  // 0 to 3 idle cycles
        repeat (n) @(posedge clk);
    endtask

    // One APB transfer, setup then access until pready
    task automatic apbTransfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               output logic [31:0] rdata, output logic err);
        int   cycles;
        logic done;
        rdata  = '0;
        err    = 1'b0;
        done   = 1'b0;
        cycles = 0;
        @(posedge clk);
        req.psel    <= 1'b1;
        req.penable <= 1'b0;
        req.pwrite  <= write;
        req.paddr   <= addr;
        req.pwdata  <= wdata;
        req.pstrb   <= write ? strb : 4'h0;  // No lanes on reads
        @(posedge clk);
        req.penable <= 1'b1;
        while (!done && cycles < TimeoutCycles) begin
            @(negedge clk);  // Mid cycle, response settled
            if (rsp.pready) begin
                done  = 1'b1;
                rdata = rsp.prdata;
                err   = rsp.pslverr;
            end
            @(posedge clk);  // Completing edge or a wait state
            cycles++;
        end
        req.psel    <= 1'b0;
        req.penable <= 1'b0;
        if (!done) begin
            timedOut = 1'b1;
            failCount++;
            $display("Timeout at %0t: no pready within %0d cycles for address 0x%08h",
                     $time, TimeoutCycles, addr);
        end
    endtask

    // Seed, then ten reads against the model
    task automatic seedAndCheck(input logic [31:0] addr, input logic [31:0] seed);
        logic [31:0] model;
        logic [31:0] rdata;
        logic        err;
        model = (seed != '0) ? seed : ModelDefault;  // Zero seed falls back
        apbTransfer(1'b1, addr, seed, 4'hf, rdata, err);
        for (int i = 0; i < 10 && !timedOut; i++) begin
            idleRandom();
            apbTransfer(1'b0, addr, '0, 4'h0, rdata, err);
            if (!timedOut) begin
                checkValue($sformatf("LFSR read %0d after seed 0x%08h", i, seed),
                           "prdata", rdata, model);
            end
            model = lfsrStep(model);
        end
    endtask

    task automatic runStimFile();
        int          fd;
        int          code;
        string       line;
        string       opStr;
        string       expStr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] expVal;
        logic [3:0]  strb;
        logic        err;
        fd = $fopen(StimPath, "r");
        if (fd == 0) begin
            failCount++;
            $display("Could not open the stimulus file %s", StimPath);
        end else begin
            while (!$feof(fd) && !timedOut) begin
                code = $fgets(line, fd);
                if (code > 1 && line.getc(0) != "#") begin  // Skip blanks and comments
                    code = $sscanf(line, "%s %h %h %h %s", opStr, addr, wdata, strb, expStr);
                    if (code != 5) begin
                        failCount++;
                        $display("Malformed stimulus line: %s", line);
                    end else if (opStr == "L") begin
                        seedAndCheck(addr, wdata);
                    end else begin
                        idleRandom();
                        apbTransfer(opStr == "W", addr, wdata, strb, rdata, err);
                        if (!timedOut && expStr == "ERR") begin
                            checkValue($sformatf("%s 0x%08h flags an error", opStr, addr),
                                       "pslverr", {31'b0, err}, 32'h1);
                        end else if (!timedOut && opStr == "W") begin
                            checkValue($sformatf("W 0x%08h accepted", addr),
                                       "pslverr", {31'b0, err}, 32'h0);
                        end else if (!timedOut) begin
                            code = $sscanf(expStr, "%h", expVal);
                            checkValue($sformatf("R 0x%08h data", addr), "prdata", rdata, expVal);
                            checkValue($sformatf("R 0x%08h accepted", addr),
                                       "pslverr", {31'b0, err}, 32'h0);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic stopwatchChecks();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b1, SwCtrl, 32'h2, 4'hf, rdata, err);  // Clear, run off
        apbTransfer(1'b0, SwCount, '0, 4'h0, a, err);
        idleRandom();
        idleRandom();
        apbTransfer(1'b0, SwCount, '0, 4'h0, b, err);
        if (!timedOut) begin
            checkValue("stopped count holds", "prdata", b, a);
            apbTransfer(1'b1, SwCtrl, 32'h1, 4'hf, rdata, err);  // Run
            apbTransfer(1'b0, SwCount, '0, 4'h0, a, err);
            repeat (MinRunCycles) @(posedge clk);
            apbTransfer(1'b0, SwCount, '0, 4'h0, b, err);
        end
        if (!timedOut) begin
            checkTrue(b >= a + 32'd1, "running count advances",
                      $sformatf("count did not advance, 0x%08h then 0x%08h", a, b));
            apbTransfer(1'b1, SwCtrl, 32'h2, 4'hf, rdata, err);
            apbTransfer(1'b0, SwCount, '0, 4'h0, a, err);
        end
        if (!timedOut) begin
            checkValue("clear returns count to 0", "prdata", a, 32'h0);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        req       = '0;
        rstN      = 1'b0;
        testCount = 0;
        passCount = 0;
        failCount = 0;
        timedOut  = 1'b0;
        void'($urandom(32'he3ba));
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);  // Idle bus right after reset
        checkValue("pready low while idle", "pready", {31'b0, rsp.pready}, 32'h0);
        checkValue("pslverr low while idle", "pslverr", {31'b0, rsp.pslverr}, 32'h0);
        apbTransfer(1'b0, SwCount, '0, 4'h0, rdata, err);  // Fresh from reset
        if (!timedOut) begin
            checkValue("stopwatch count after reset", "prdata", rdata, 32'h0);
            runStimFile();
        end
        if (!timedOut) begin
            stopwatchChecks();
        end
        $display("Tests: %0d, passed: %0d, failed: %0d", testCount, passCount, failCount);
        if (failCount == 0 && testCount > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tb/stimInput.txt
# op addr wdata strb expect; op W write, R read, L seed the LFSR and read it ten times
# expect is hex read data, ERR for pslverr, or - when there is nothing to compare
W 10010000 deadbeef f -
W 10010004 12345678 f -
W 100103fc a5a5a5a5 f -
R 10010000 0 0 deadbeef
R 10010004 0 0 12345678
R 100103fc 0 0 a5a5a5a5
W 10010010 11223344 f -
W 10010010 aabbccdd 3 -
R 10010010 0 0 1122ccdd
W 10010010 99000000 8 -
R 10010010 0 0 9922ccdd
W 10010020 cafef00d f -
W 10010020 00000077 1 -
R 10010020 0 0 cafef077
W 10010400 ffffffff f ERR
R 10010400 0 0 ERR
W 1000fffc ffffffff f ERR
W 00000000 ffffffff f ERR
R ff200070 0 0 ERR
W ff200040 ffffffff f ERR
R 10010000 0 0 deadbeef
R 10010004 0 0 12345678
R 10010010 0 0 9922ccdd
L ff200060 00000001 f -
L ff200060 c0ffee11 f -
L ff200060 00000000 f -
R ff200064 0 0 00000000

//--- tb.f
src/busPkg.sv
src/periphPkg.sv
src/apbDecoder.sv
src/dataRam.sv
src/stopwatchTimer.sv
src/lfsrReg.sv
src/periphSubsystem.sv
tb/tbPeriph.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbPeriph
FILELIST  = tb.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJDIR)
